// ==== logic/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

   localparam int xlen      = 32;
   localparam int nreg      = 32;
   localparam int link_step = 4;    // pc step to the next instruction

   typedef logic [xlen-1:0]          word_t;
   typedef logic [$clog2(nreg)-1:0]  reg_idx_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_slt,    // signed
      alu_sltu,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_lui     // b operand straight through
   } alu_op_t;

   typedef enum logic [2:0] {
      bru_beq,
      bru_bne,
      bru_blt,
      bru_bge,
      bru_bltu,
      bru_bgeu,
      bru_jmp,
      bru_jal
   } bru_op_t;

endpackage

`default_nettype wire

// ==== logic/exu_fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// m and w stage results, shared by bypass and the register file write port
interface exu_fwd_if;
   import exu_pkg::*;

   logic     m_wen;
   reg_idx_t m_rd;
   word_t    m_data;
   logic     w_wen;
   reg_idx_t w_rd;
   word_t    w_data;

   modport pipe (output m_wen, m_rd, m_data, w_wen, w_rd, w_data);
   modport byp  (input  m_wen, m_rd, m_data, w_wen, w_rd, w_data);
   modport rf   (input  w_wen, w_rd, w_data);

endinterface

`default_nettype wire

// ==== logic/exu_rf.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_rf (
   input  logic              clk,
   input  logic              arst_n,
   input  exu_pkg::reg_idx_t rs1,
   input  exu_pkg::reg_idx_t rs2,
   output exu_pkg::word_t    rs1_data,
   output exu_pkg::word_t    rs2_data,
   exu_fwd_if.rf             fwd
);
   import exu_pkg::*;

   word_t regs [nreg];
   logic  wr_act;

   assign wr_act = fwd.w_wen && (fwd.w_rd != '0);  // r0 never written

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < nreg; i++)
            regs[i] <= '0;
      end else if (wr_act) begin
         regs[fwd.w_rd] <= fwd.w_data;
      end
   end

   // write-first read port
   always_comb begin
      rs1_data = regs[rs1];
      rs2_data = regs[rs2];
      if (wr_act && (fwd.w_rd == rs1))
         rs1_data = fwd.w_data;
      if (wr_act && (fwd.w_rd == rs2))
         rs2_data = fwd.w_data;
   end

endmodule

`default_nettype wire

// ==== logic/exu_byp.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_byp (
   input  exu_pkg::reg_idx_t rs1_e,
   input  exu_pkg::reg_idx_t rs2_e,
   input  exu_pkg::word_t    rs1_data_e,
   input  exu_pkg::word_t    rs2_data_e,
   exu_fwd_if.byp            fwd,
   output exu_pkg::word_t    rs1_fwd_e,
   output exu_pkg::word_t    rs2_fwd_e
);
   import exu_pkg::*;

   // newest producer wins, m before w
   always_comb begin
      rs1_fwd_e = rs1_data_e;
      if (rs1_e != '0) begin                       // r0 is never a forward target
         if (fwd.m_wen && (fwd.m_rd == rs1_e))
            rs1_fwd_e = fwd.m_data;
         else if (fwd.w_wen && (fwd.w_rd == rs1_e))
            rs1_fwd_e = fwd.w_data;
      end
   end

   always_comb begin
      rs2_fwd_e = rs2_data_e;
      if (rs2_e != '0) begin
         if (fwd.m_wen && (fwd.m_rd == rs2_e))
            rs2_fwd_e = fwd.m_data;
         else if (fwd.w_wen && (fwd.w_rd == rs2_e))
            rs2_fwd_e = fwd.w_data;
      end
   end

endmodule

`default_nettype wire

// ==== logic/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
   input  exu_pkg::alu_op_t op,
   input  logic             a_pc,
   input  logic             b_imm,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   imm,
   input  exu_pkg::word_t   rs1,
   input  exu_pkg::word_t   rs2,
   output exu_pkg::word_t   result
);
   import exu_pkg::*;

   localparam int shw = $clog2(xlen);

   word_t          a;
   word_t          b;
   logic [shw-1:0] shamt;
   logic           lt_s;
   logic           lt_u;

   assign a     = a_pc  ? pc  : rs1;
   assign b     = b_imm ? imm : rs2;
   assign shamt = b[shw-1:0];   // low bits of b only

   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         alu_add:  result = a + b;
         alu_sub:  result = a - b;
         alu_slt:  result = word_t'(lt_s);
         alu_sltu: result = word_t'(lt_u);
         alu_and:  result = a & b;
         alu_or:   result = a | b;
         alu_xor:  result = a ^ b;
         alu_nor:  result = ~(a | b);
         alu_sll:  result = a << shamt;
         alu_srl:  result = a >> shamt;
         alu_sra:  result = word_t'($signed(a) >>> shamt);
         alu_lui:  result = b;
         default:  result = '0;           // unused encodings
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/exu_bru.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_bru (
   input  exu_pkg::bru_op_t op,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   offset,
   input  exu_pkg::word_t   rs1,
   input  exu_pkg::word_t   rs2,
   output logic             taken,
   output exu_pkg::word_t   target,
   output exu_pkg::word_t   link
);
   import exu_pkg::*;

   logic eq;
   logic lt_s;
   logic lt_u;

   assign eq   = rs1 == rs2;
   assign lt_s = $signed(rs1) < $signed(rs2);
   assign lt_u = rs1 < rs2;

   always_comb begin
      case (op)
         bru_beq:  taken = eq;
         bru_bne:  taken = !eq;
         bru_blt:  taken = lt_s;
         bru_bge:  taken = !lt_s;
         bru_bltu: taken = lt_u;
         bru_bgeu: taken = !lt_u;
         default:  taken = 1'b1;   // jmp, jal
      endcase
   end

   assign target = pc + offset;
   assign link   = pc + word_t'(link_step);

endmodule

`default_nettype wire

// ==== logic/exu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_pipe (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              vld_d,
   input  logic              wen_d,
   input  logic              alu_vld_d,
   input  logic              bru_vld_d,
   input  logic              alu_a_pc_d,
   input  logic              alu_b_imm_d,
   input  exu_pkg::word_t    pc_d,
   input  exu_pkg::word_t    imm_d,
   input  exu_pkg::word_t    bru_offset_d,
   input  exu_pkg::word_t    rs1_data_d,
   input  exu_pkg::word_t    rs2_data_d,
   input  exu_pkg::reg_idx_t rs1_d,
   input  exu_pkg::reg_idx_t rs2_d,
   input  exu_pkg::reg_idx_t rd_d,
   input  exu_pkg::alu_op_t  alu_op_d,
   input  exu_pkg::bru_op_t  bru_op_d,
   output exu_pkg::reg_idx_t rs1_e,
   output exu_pkg::reg_idx_t rs2_e,
   output exu_pkg::word_t    rs1_data_e,
   output exu_pkg::word_t    rs2_data_e,
   output exu_pkg::word_t    pc_e,
   output exu_pkg::word_t    imm_e,
   output exu_pkg::word_t    bru_offset_e,
   output exu_pkg::alu_op_t  alu_op_e,
   output logic              alu_a_pc_e,
   output logic              alu_b_imm_e,
   output exu_pkg::bru_op_t  bru_op_e,
   input  exu_pkg::word_t    alu_result_e,
   input  logic              bru_taken_e,
   input  exu_pkg::word_t    bru_target_e,
   input  exu_pkg::word_t    bru_link_e,
   exu_fwd_if.pipe           fwd,
   output logic              branch,
   output exu_pkg::word_t    brn_addr,
   output logic              wb_vld,
   output exu_pkg::reg_idx_t wb_rd,
   output exu_pkg::word_t    wb_data
);
   import exu_pkg::*;

   logic     vld_e, wen_e, bru_vld_e;
   logic     vld_m, wen_m, bru_vld_m, taken_m;
   logic     vld_w, wen_w, taken_w;
   reg_idx_t rd_e, rd_m, rd_w;
   word_t    alu_res_m, link_m, target_m, data_m;
   word_t    data_w, target_w;
   logic     flush;

   // taken branch in w kills the instructions now in e and m
   assign flush = vld_w & taken_w;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_e     <= 1'b0;
         wen_e     <= 1'b0;
         bru_vld_e <= 1'b0;
         vld_m     <= 1'b0;
         wen_m     <= 1'b0;
         bru_vld_m <= 1'b0;
         taken_m   <= 1'b0;
         vld_w     <= 1'b0;
         wen_w     <= 1'b0;
         taken_w   <= 1'b0;
      end else begin
         vld_e     <= vld_d;                             // new one is never flushed
         wen_e     <= wen_d & (alu_vld_d | bru_vld_d);   // bubbles write nothing
         bru_vld_e <= bru_vld_d;
         vld_m     <= vld_e & ~flush;
         wen_m     <= wen_e;
         bru_vld_m <= bru_vld_e;
         taken_m   <= bru_vld_e & bru_taken_e;
         vld_w     <= vld_m & ~flush;
         wen_w     <= wen_m;
         taken_w   <= taken_m;
      end
   end

   // d -> e payload
   always_ff @(posedge clk) begin
      if (vld_d) begin
         rs1_e        <= rs1_d;
         rs2_e        <= rs2_d;
         rd_e         <= rd_d;
         rs1_data_e   <= rs1_data_d;
         rs2_data_e   <= rs2_data_d;
         pc_e         <= pc_d;
         imm_e        <= imm_d;
         bru_offset_e <= bru_offset_d;
         alu_op_e     <= alu_op_d;
         alu_a_pc_e   <= alu_a_pc_d;
         alu_b_imm_e  <= alu_b_imm_d;
         bru_op_e     <= bru_op_d;
      end
   end

   // e -> m -> w payload
   always_ff @(posedge clk) begin
      rd_m      <= rd_e;
      alu_res_m <= alu_result_e;
      link_m    <= bru_link_e;
      target_m  <= bru_target_e;
      rd_w      <= rd_m;
      data_w    <= data_m;
      target_w  <= target_m;
   end

   assign data_m = bru_vld_m ? link_m : alu_res_m;   // jal link

   assign fwd.m_wen  = vld_m & wen_m;
   assign fwd.m_rd   = rd_m;
   assign fwd.m_data = data_m;
   assign fwd.w_wen  = vld_w & wen_w;
   assign fwd.w_rd   = rd_w;
   assign fwd.w_data = data_w;

   assign branch   = flush;
   assign brn_addr = target_w;
   assign wb_vld   = vld_w & wen_w;
   assign wb_rd    = rd_w;
   assign wb_data  = data_w;

endmodule

`default_nettype wire

// ==== logic/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              ifu_exu_vld_d,
   input  logic              ifu_exu_wen_d,
   input  logic              ifu_exu_alu_vld_d,
   input  logic              ifu_exu_alu_a_pc_d,
   input  logic              ifu_exu_alu_b_imm_d,
   input  logic              ifu_exu_bru_vld_d,
   input  exu_pkg::word_t    ifu_exu_pc_d,
   input  exu_pkg::word_t    ifu_exu_imm_d,
   input  exu_pkg::word_t    ifu_exu_bru_offset_d,
   input  exu_pkg::reg_idx_t ifu_exu_rs1_d,
   input  exu_pkg::reg_idx_t ifu_exu_rs2_d,
   input  exu_pkg::reg_idx_t ifu_exu_rd_d,
   input  exu_pkg::alu_op_t  ifu_exu_alu_op_d,
   input  exu_pkg::bru_op_t  ifu_exu_bru_op_d,
   output logic              exu_ifu_branch,
   output exu_pkg::word_t    exu_ifu_brn_addr,
   output logic              exu_wb_vld,
   output exu_pkg::reg_idx_t exu_wb_rd,
   output exu_pkg::word_t    exu_wb_data
);
   import exu_pkg::*;

   word_t    rs1_data_d, rs2_data_d;
   reg_idx_t rs1_e, rs2_e;
   word_t    rs1_data_e, rs2_data_e;
   word_t    rs1_fwd_e, rs2_fwd_e;
   word_t    pc_e, imm_e, bru_offset_e;
   alu_op_t  alu_op_e;
   logic     alu_a_pc_e, alu_b_imm_e;
   bru_op_t  bru_op_e;
   word_t    alu_result_e;
   logic     bru_taken_e;
   word_t    bru_target_e, bru_link_e;

   exu_fwd_if fwd0 ();

   exu_rf u_rf (
      .clk      (clk),
      .arst_n   (arst_n),
      .rs1      (ifu_exu_rs1_d),   // read in d
      .rs2      (ifu_exu_rs2_d),
      .rs1_data (rs1_data_d),
      .rs2_data (rs2_data_d),
      .fwd      (fwd0.rf)
   );

   exu_byp u_byp (
      .rs1_e      (rs1_e),
      .rs2_e      (rs2_e),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .fwd        (fwd0.byp),
      .rs1_fwd_e  (rs1_fwd_e),
      .rs2_fwd_e  (rs2_fwd_e)
   );

   exu_alu u_alu (
      .op     (alu_op_e),
      .a_pc   (alu_a_pc_e),
      .b_imm  (alu_b_imm_e),
      .pc     (pc_e),
      .imm    (imm_e),
      .rs1    (rs1_fwd_e),
      .rs2    (rs2_fwd_e),
      .result (alu_result_e)
   );

   exu_bru u_bru (
      .op     (bru_op_e),
      .pc     (pc_e),
      .offset (bru_offset_e),
      .rs1    (rs1_fwd_e),
      .rs2    (rs2_fwd_e),
      .taken  (bru_taken_e),
      .target (bru_target_e),
      .link   (bru_link_e)
   );

   exu_pipe u_pipe (
      .clk          (clk),
      .arst_n       (arst_n),
      .vld_d        (ifu_exu_vld_d),
      .wen_d        (ifu_exu_wen_d),
      .alu_vld_d    (ifu_exu_alu_vld_d),
      .bru_vld_d    (ifu_exu_bru_vld_d),
      .alu_a_pc_d   (ifu_exu_alu_a_pc_d),
      .alu_b_imm_d  (ifu_exu_alu_b_imm_d),
      .pc_d         (ifu_exu_pc_d),
      .imm_d        (ifu_exu_imm_d),
      .bru_offset_d (ifu_exu_bru_offset_d),
      .rs1_data_d   (rs1_data_d),
      .rs2_data_d   (rs2_data_d),
      .rs1_d        (ifu_exu_rs1_d),
      .rs2_d        (ifu_exu_rs2_d),
      .rd_d         (ifu_exu_rd_d),
      .alu_op_d     (ifu_exu_alu_op_d),
      .bru_op_d     (ifu_exu_bru_op_d),
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .rs1_data_e   (rs1_data_e),
      .rs2_data_e   (rs2_data_e),
      .pc_e         (pc_e),
      .imm_e        (imm_e),
      .bru_offset_e (bru_offset_e),
      .alu_op_e     (alu_op_e),
      .alu_a_pc_e   (alu_a_pc_e),
      .alu_b_imm_e  (alu_b_imm_e),
      .bru_op_e     (bru_op_e),
      .alu_result_e (alu_result_e),
      .bru_taken_e  (bru_taken_e),
      .bru_target_e (bru_target_e),
      .bru_link_e   (bru_link_e),
      .fwd          (fwd0.pipe),
      .branch       (exu_ifu_branch),
      .brn_addr     (exu_ifu_brn_addr),
      .wb_vld       (exu_wb_vld),
      .wb_rd        (exu_wb_rd),
      .wb_data      (exu_wb_data)
   );

endmodule

`default_nettype wire

// ==== tests/exu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_checker (
   input logic              clk,
   input logic              arst_n,
   input logic              exu_ifu_branch,
   input exu_pkg::word_t    exu_ifu_brn_addr,
   input logic              exu_wb_vld,
   input exu_pkg::reg_idx_t exu_wb_rd,
   input exu_pkg::word_t    exu_wb_data
);

   int unsigned fails = 0;

   branch_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      exu_ifu_branch |=> !exu_ifu_branch)
      else begin
         $error("redirect pulse lasted more than one cycle");
         fails++;
      end

   // both younger slots are killed
   wb_quiet_after_branch: assert property (@(posedge clk) disable iff (!arst_n)
      exu_ifu_branch |=> !exu_wb_vld [*2])
      else begin
         $error("write-back seen in a slot killed by a taken branch");
         fails++;
      end

   ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown({exu_ifu_branch, exu_wb_vld}))
      else begin
         $error("branch or write-back valid is unknown");
         fails++;
      end

   // payload only has to be known while it is qualified
   wb_known: assert property (@(posedge clk) disable iff (!arst_n)
      exu_wb_vld |-> !$isunknown({exu_wb_rd, exu_wb_data}))
      else begin
         $error("write-back index or data is unknown");
         fails++;
      end

   addr_known: assert property (@(posedge clk) disable iff (!arst_n)
      exu_ifu_branch |-> !$isunknown(exu_ifu_brn_addr))
      else begin
         $error("redirect address is unknown");
         fails++;
      end

endmodule

bind exu_top exu_checker chk0 (
   .clk              (clk),
   .arst_n           (arst_n),
   .exu_ifu_branch   (exu_ifu_branch),
   .exu_ifu_brn_addr (exu_ifu_brn_addr),
   .exu_wb_vld       (exu_wb_vld),
   .exu_wb_rd        (exu_wb_rd),
   .exu_wb_data      (exu_wb_data)
);

`default_nettype wire

// ==== tests/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
   import exu_pkg::*;

   localparam int max_ent  = 256;
   localparam int wb_delay = 3;    // falling edges from drive to the w stage

   typedef struct packed {
      logic     wen;
      logic     alu;
      logic     bru;
      logic     a_pc;
      logic     b_imm;
      word_t    pc;
      word_t    imm;
      word_t    off;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      alu_op_t  aop;
      bru_op_t  bop;
      logic     flushed;    // killed by an older taken branch
      logic     e_wb;
      word_t    e_data;
      logic     e_br;
      word_t    e_addr;
   } ent_t;

   logic     clk = 1'b0;
   logic     arst_n;
   logic     vld_d, wen_d, alu_vld_d, alu_a_pc_d, alu_b_imm_d, bru_vld_d;
   word_t    pc_d, imm_d, bru_offset_d;
   reg_idx_t rs1_d, rs2_d, rd_d;
   alu_op_t  alu_op_d;
   bru_op_t  bru_op_d;
   logic     branch;
   word_t    brn_addr;
   logic     wb_vld;
   reg_idx_t wb_rd;
   word_t    wb_data;

   ent_t     tbl [max_ent];
   string    tname [max_ent];
   int       n_ent = 0;
   word_t    model_rf [nreg];    // architectural register state
   int       flush_left = 0;
   word_t    lfsr = 32'hd05f_03e1;
   int       cycles = 0;
   int       cycle_limit = 1000;
   int       n_run = 0;
   int       n_fail = 0;
   int       pa [4] = '{7, 7, 9, 6};    // branch operand pairs
   int       pb [4] = '{7, 9, 7, 7};
   string    cname [4] = '{"eq", "lt", "gt", "neg"};

   always #20 clk = ~clk;

   exu_top dut0 (
      .clk (clk), .arst_n (arst_n),
      .ifu_exu_vld_d (vld_d), .ifu_exu_wen_d (wen_d),
      .ifu_exu_alu_vld_d (alu_vld_d), .ifu_exu_alu_a_pc_d (alu_a_pc_d),
      .ifu_exu_alu_b_imm_d (alu_b_imm_d), .ifu_exu_bru_vld_d (bru_vld_d),
      .ifu_exu_pc_d (pc_d), .ifu_exu_imm_d (imm_d), .ifu_exu_bru_offset_d (bru_offset_d),
      .ifu_exu_rs1_d (rs1_d), .ifu_exu_rs2_d (rs2_d), .ifu_exu_rd_d (rd_d),
      .ifu_exu_alu_op_d (alu_op_d), .ifu_exu_bru_op_d (bru_op_d),
      .exu_ifu_branch (branch), .exu_ifu_brn_addr (brn_addr),
      .exu_wb_vld (wb_vld), .exu_wb_rd (wb_rd), .exu_wb_data (wb_data)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   // galois form, one step per bit
   function automatic word_t lfsr_next(input word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic word_t rand_word(input int nbits);
      word_t v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         v    = {v[xlen-2:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
      int sh;
      sh = int'(b[4:0]);
      case (op)
         alu_add:  return a + b;
         alu_sub:  return a + ~b + 32'd1;
         alu_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
         alu_sltu: return {31'b0, a < b};
         alu_and:  return a & b;
         alu_or:   return a | b;
         alu_xor:  return a ^ b;
         alu_nor:  return ~(a | b);
         alu_sll:  return a << sh;
         alu_srl:  return a >> sh;
         alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
         default:  return b;    // lui
      endcase
   endfunction

   function automatic logic taken_ref(input bru_op_t op, input word_t a, input word_t b);
      logic ltu;
      logic lts;
      ltu = a < b;
      lts = (a[31] != b[31]) ? a[31] : ltu;    // negative side is smaller
      case (op)
         bru_beq:  return a == b;
         bru_bne:  return a != b;
         bru_blt:  return lts;
         bru_bge:  return !lts;
         bru_bltu: return ltu;
         bru_bgeu: return !ltu;
         default:  return 1'b1;
      endcase
   endfunction

   function automatic ent_t alu_i(input alu_op_t op, input int rd, input int rs1, input int rs2,
                                  input int a_pc, input int b_imm, input word_t imm);
      ent_t e;
      e       = '0;
      e.wen   = 1'b1;
      e.alu   = 1'b1;
      e.aop   = op;
      e.rd    = reg_idx_t'(rd);
      e.rs1   = reg_idx_t'(rs1);
      e.rs2   = reg_idx_t'(rs2);
      e.a_pc  = (a_pc != 0);
      e.b_imm = (b_imm != 0);
      e.imm   = imm;
      return e;
   endfunction

   function automatic ent_t bru_i(input bru_op_t op, input int rd, input int rs1, input int rs2,
                                  input int wen, input word_t off);
      ent_t e;
      e     = '0;
      e.wen = (wen != 0);
      e.bru = 1'b1;
      e.bop = op;
      e.rd  = reg_idx_t'(rd);
      e.rs1 = reg_idx_t'(rs1);
      e.rs2 = reg_idx_t'(rs2);
      e.off = off;
      return e;
   endfunction

   // appends an entry and runs it through the register model
   task automatic push(input string nm, input ent_t e);
      word_t a;
      word_t b;
      a    = model_rf[e.rs1];
      b    = model_rf[e.rs2];
      e.pc = 32'h0000_1000 + word_t'(4 * n_ent);
      if (flush_left > 0) begin
         e.flushed = 1'b1;
         flush_left--;
      end else if (e.alu) begin
         e.e_wb   = e.wen;
         e.e_data = alu_ref(e.aop, e.a_pc ? e.pc : a, e.b_imm ? e.imm : b);
      end else if (e.bru) begin
         e.e_wb   = e.wen;
         e.e_data = e.pc + word_t'(link_step);
         e.e_br   = taken_ref(e.bop, a, b);
         e.e_addr = e.pc + e.off;
         if (e.e_br)
            flush_left = 2;
      end
      if (e.e_wb && (e.rd != '0))
         model_rf[e.rd] = e.e_data;    // r0 stays zero
      tbl[n_ent]   = e;
      tname[n_ent] = nm;
      n_ent++;
   endtask

   // the two slots a taken branch kills, then one that must run
   task automatic shadows(input string base);
      push({base, "_sh1"}, alu_i(alu_add, 28, 28, 0, 0, 1, 32'd1));
      push({base, "_sh2"}, alu_i(alu_add, 29, 29, 28, 0, 0, '0));
      push({base, "_next"}, alu_i(alu_xor, 30, 28, 29, 0, 0, '0));
   endtask

   task automatic drive(input ent_t e, input logic vld);
      vld_d        = vld;
      wen_d        = e.wen;
      alu_vld_d    = e.alu;
      bru_vld_d    = e.bru;
      alu_a_pc_d   = e.a_pc;
      alu_b_imm_d  = e.b_imm;
      pc_d         = e.pc;
      imm_d        = e.imm;
      bru_offset_d = e.off;
      rs1_d        = e.rs1;
      rs2_d        = e.rs2;
      rd_d         = e.rd;
      alu_op_d     = e.aop;
      bru_op_d     = e.bop;
   endtask

   task automatic check_ent(input int i);
      ent_t e;
      logic ok;
      e  = tbl[i];
      ok = 1'b1;
      assert (wb_vld === e.e_wb) else begin
         $display("Fail %s wb_vld expected %b actual %b", tname[i], e.e_wb, wb_vld);
         ok = 1'b0;
      end
      if (e.e_wb) begin
         assert (wb_rd === e.rd) else begin
            $display("Fail %s wb_rd expected %0d actual %0d", tname[i], e.rd, wb_rd);
            ok = 1'b0;
         end
         assert (wb_data === e.e_data) else begin
            $display("Fail %s wb_data expected %h actual %h", tname[i], e.e_data, wb_data);
            ok = 1'b0;
         end
      end
      assert (branch === e.e_br) else begin
         $display("Fail %s branch expected %b actual %b", tname[i], e.e_br, branch);
         ok = 1'b0;
      end
      if (e.e_br) begin
         assert (brn_addr === e.e_addr) else begin
            $display("Fail %s brn_addr expected %h actual %h", tname[i], e.e_addr, brn_addr);
            ok = 1'b0;
         end
      end
      n_run++;
      if (ok)
         $display("pass %s%s", tname[i], e.flushed ? " (flushed)" : "");
      else
         n_fail++;
   endtask

   initial begin
      alu_op_t aop;
      bru_op_t bop;
      ent_t    bub;
      arst_n = 1'b0;
      drive('0, 1'b0);
      for (int k = 0; k < nreg; k++)
         model_rf[k] = '0;

      // every register reads zero out of reset, on both ports
      for (int k = 1; k < nreg; k++)
         push($sformatf("rst_r%0d", k), alu_i(alu_or, k, k, (k + 1) % nreg, 0, 0, '0));
      for (int k = 1; k <= 4; k++)
         push($sformatf("seed_lui_r%0d", k), alu_i(alu_lui, k, 0, 0, 0, 1, rand_word(32)));
      push("seed_add_r5", alu_i(alu_add, 5, 0, 0, 0, 1, rand_word(32)));
      push("lui_r6_min", alu_i(alu_lui, 6, 0, 0, 0, 1, 32'h8000_0000));
      push("lui_r7", alu_i(alu_lui, 7, 0, 0, 0, 1, 32'd5));
      push("lui_r8_ones", alu_i(alu_lui, 8, 0, 0, 0, 1, 32'hffff_ffff));
      push("lui_r9", alu_i(alu_lui, 9, 0, 0, 0, 1, 32'd9));
      for (int k = 0; k < 12; k++) begin
         aop = alu_op_t'(k);
         push($sformatf("%s_rr", aop.name()), alu_i(aop, 10, 1, 2, 0, 0, '0));
         push($sformatf("%s_ri", aop.name()), alu_i(aop, 11, 3, 0, 0, 1, rand_word(32)));
      end
      push("add_pc_imm", alu_i(alu_add, 12, 0, 0, 1, 1, 32'h10));
      push("sub_pc_reg", alu_i(alu_sub, 12, 0, 4, 1, 0, '0));
      push("slt_neg_pos", alu_i(alu_slt, 12, 6, 7, 0, 0, '0));
      push("sltu_neg_pos", alu_i(alu_sltu, 12, 6, 7, 0, 0, '0));
      push("slt_pos_neg", alu_i(alu_slt, 12, 7, 6, 0, 0, '0));
      push("sltu_pos_neg", alu_i(alu_sltu, 12, 7, 6, 0, 0, '0));
      push("slt_ones_pos", alu_i(alu_slt, 12, 8, 7, 0, 0, '0));
      push("sra_min_r7", alu_i(alu_sra, 12, 6, 7, 0, 0, '0));
      push("srl_min_r7", alu_i(alu_srl, 12, 6, 7, 0, 0, '0));
      push("sll_imm_hi_bits", alu_i(alu_sll, 12, 8, 0, 0, 1, 32'hffff_ffe3));
      push("sra_min_31", alu_i(alu_sra, 12, 6, 0, 0, 1, 32'd31));

      // hazards at distance 1, 2 and 3
      push("dep1_src", alu_i(alu_add, 13, 1, 2, 0, 0, '0));
      push("dep1_rs1", alu_i(alu_sub, 14, 13, 3, 0, 0, '0));
      push("dep1_rs2", alu_i(alu_xor, 15, 4, 14, 0, 0, '0));
      push("dep2_src", alu_i(alu_add, 16, 1, 3, 0, 0, '0));
      push("dep2_fill", alu_i(alu_or, 17, 2, 4, 0, 0, '0));
      push("dep2_use", alu_i(alu_or, 18, 16, 5, 0, 0, '0));
      push("dep3_src", alu_i(alu_and, 19, 2, 3, 0, 0, '0));
      push("dep3_fill_a", alu_i(alu_add, 20, 4, 5, 0, 0, '0));
      push("dep3_fill_b", alu_i(alu_sub, 21, 5, 4, 0, 0, '0));
      push("dep3_use", alu_i(alu_add, 22, 19, 19, 0, 0, '0));
      push("newest_old", alu_i(alu_add, 23, 1, 1, 0, 0, '0));
      push("newest_new", alu_i(alu_add, 23, 2, 2, 0, 0, '0));
      push("newest_use", alu_i(alu_add, 24, 23, 0, 0, 0, '0));

      // r0 as destination and as a source right after
      push("r0_write", alu_i(alu_add, 0, 1, 2, 0, 0, '0));
      push("r0_dist1", alu_i(alu_add, 25, 0, 3, 0, 0, '0));
      push("r0_dist2", alu_i(alu_or, 26, 0, 4, 0, 0, '0));
      push("r0_lui", alu_i(alu_lui, 0, 0, 0, 0, 1, rand_word(32)));
      push("r0_dist1_rs2", alu_i(alu_add, 27, 3, 0, 0, 0, '0));
      bub     = '0;
      bub.wen = 1'b1;    // valid, but neither unit selected
      push("bubble_wen", bub);

      push("brfwd_src", alu_i(alu_add, 10, 7, 0, 0, 0, '0));
      push("beq_fwd_m", bru_i(bru_beq, 0, 10, 7, 0, 32'h40));
      shadows("beq_fwd_m");
      for (int k = 0; k < 6; k++) begin
         bop = bru_op_t'(k);
         for (int c = 0; c < 4; c++) begin
            push($sformatf("%s_%s", bop.name(), cname[c]),
                 bru_i(bop, 0, pa[c], pb[c], 0, 32'h100));
            shadows($sformatf("%s_%s", bop.name(), cname[c]));
         end
      end
      push("jmp_back", bru_i(bru_jmp, 0, 0, 0, 0, 32'hffff_ff00));
      shadows("jmp_back");
      push("jal_r31", bru_i(bru_jal, 31, 0, 0, 1, 32'h80));
      push("jal_sh1", alu_i(alu_add, 31, 31, 0, 0, 1, 32'h7));
      push("jal_sh2", alu_i(alu_add, 30, 30, 0, 0, 1, 32'h3));
      push("jal_link_read", alu_i(alu_add, 30, 31, 0, 0, 0, '0));

      cycle_limit = n_ent + 3 + 10;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      n_run++;
      assert (branch === 1'b0 && wb_vld === 1'b0) else begin
         $display("outputs not idle after reset: branch %b wb_vld %b", branch, wb_vld);
         n_fail++;
      end

      for (int j = 0; j < n_ent + wb_delay; j++) begin
         @(negedge clk);
         if (j >= wb_delay)
            check_ent(j - wb_delay);
         if (j < n_ent)
            drive(tbl[j], 1'b1);
         else
            drive('0, 1'b0);
      end

      if (dut0.chk0.fails != 0)
         $display("protocol checker reported %0d assertion failures", dut0.chk0.fails);
      $display("%0d tests, %0d passed, %0d failed", n_run, n_run - n_fail, n_fail);
      if (n_fail == 0 && dut0.chk0.fails == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== exu.f ====
logic/exu_pkg.sv
logic/exu_fwd_if.sv
logic/exu_rf.sv
logic/exu_byp.sv
logic/exu_alu.sv
logic/exu_bru.sv
logic/exu_pipe.sv
logic/exu_top.sv
tests/exu_checker.sv
tests/exu_tb.sv
